// File: rtl/exe_pkg.sv
package exe_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////

    localparam int OP_W  = 5;
    localparam int TAG_W = 4;

    //////////////////////////////////////////////////
    // alu opcodes
    //////////////////////////////////////////////////

    typedef enum logic [OP_W-1:0] {
        ALU_AND       = 5'd0,
        ALU_ADD       = 5'd1,
        ALU_PENC      = 5'd2,
        ALU_PASSB     = 5'd3,
        ALU_PASSA     = 5'd4,
        ALU_CLD       = 5'd5,
        ALU_STD       = 5'd6,
        ALU_CMPXCHG   = 5'd7,
        ALU_DAA       = 5'd8,
        ALU_NOT       = 5'd9,
        ALU_OR        = 5'd10,
        ALU_PADDW     = 5'd11,
        ALU_PADDD     = 5'd12,
        ALU_PACKSSWB  = 5'd13,
        ALU_PACKSSDW  = 5'd14,
        ALU_PUNPCKHBW = 5'd15,
        ALU_PUNPCKHWD = 5'd16,
        ALU_SAR       = 5'd17,
        ALU_SAL       = 5'd18
    } alu_op_e;

    // eflags subset, cf in the msb
    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
        logic df;
    } eflags_t;

    typedef struct packed {
        alu_op_e            op;
        logic [63:0]        op1;
        logic [63:0]        op2;
        logic [63:0]        op3;
        logic [31:0]        op1_orig;
        logic [2:0]         adder_imm;
        logic               and_mask;
        logic               shf_one;
        logic               cmpxchg_mem;
        eflags_t            flags;
        logic [TAG_W-1:0]   tag;
    } uop_t;

    typedef struct packed {
        logic [63:0]        result;
        logic [31:0]        op1_dest;
        eflags_t            flags;
        logic [TAG_W-1:0]   tag;
    } res_t;

    // add immediates, entry 0 is replaced by op2
    localparam logic [31:0] ADD_IMM [8] = '{
        32'd0, 32'd2, 32'd4, 32'd0,
        32'd6, 32'hFFFF_FFFE, 32'hFFFF_FFFC, 32'd0
    };

    localparam logic [63:0] AND_LOW_MASK = 64'h0000_0000_0000_FFFF;

endpackage

// File: rtl/exe_stage_if.sv
`timescale 1ns/1ps

// one handoff between pipeline stages
interface exe_stage_if #(
    parameter type payload_t = logic
);

    logic                       valid;
    logic                       ready;
    payload_t                   payload;
    logic [exe_pkg::TAG_W-1:0]  tag;

    // producer side
    modport src (
        output valid,
        output payload,
        output tag,
        input  ready
    );

    // consumer side
    modport dst (
        input  valid,
        input  payload,
        input  tag,
        output ready
    );

endinterface

// File: rtl/exe_pipe_reg.sv
`timescale 1ns/1ps

module exe_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        rst_n,
    exe_stage_if.dst    up,
    exe_stage_if.src    down
);

    logic                       valid_q;
    payload_t                   data_q;
    logic [exe_pkg::TAG_W-1:0]  tag_q;

    // free slot, or the held item leaves this cycle
    assign up.ready = !valid_q || down.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (up.ready) begin
            valid_q <= up.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (up.valid && up.ready) begin
            data_q <= up.payload;
            tag_q  <= up.tag;
        end
    end

    assign down.valid   = valid_q;
    assign down.payload = data_q;
    assign down.tag     = tag_q;

    //////////////////////////////////////////////////
    // handshake checks
    //////////////////////////////////////////////////

    // a stalled item stays offered
    a_valid_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        down.valid && !down.ready |=> down.valid
    ) else $error("pipe reg dropped valid without a transfer");

    // and stays unchanged, tag included
    a_data_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        down.valid && !down.ready |=> $stable(down.payload) && $stable(down.tag)
    ) else $error("pipe reg payload changed while stalled");

endmodule

// File: rtl/alu_int_unit.sv
`timescale 1ns/1ps

module alu_int_unit (
    input  exe_pkg::alu_op_e    op,
    input  logic [63:0]         op1,
    input  logic [63:0]         op2,
    input  logic [63:0]         op3,
    input  logic [31:0]         op1_orig,
    input  logic [2:0]          adder_imm,
    input  logic                and_mask,
    input  logic                shf_one,
    input  logic                cmpxchg_mem,
    input  logic                cf_in,
    input  logic                af_in,
    output logic [63:0]         result,
    output logic [31:0]         op1_dest,
    output logic                cout,
    output logic                aout,
    output logic                ovf,
    output logic                sh_out_bit,
    output logic                eq,
    output logic                penc_none
);

    logic [31:0]        addend;
    logic [32:0]        sum;
    logic [4:0]         shamt;
    logic signed [32:0] sar_ext;
    logic [32:0]        sal_ext;
    logic [4:0]         penc_idx;
    logic               daa_lo;
    logic               daa_hi;
    logic [7:0]         daa_byte;

    //////////////////////////////////////////////////
    // shared datapath pieces
    //////////////////////////////////////////////////

    assign addend = (adder_imm == 3'd0) ? op2[31:0] : exe_pkg::ADD_IMM[adder_imm];
    assign sum    = {1'b0, op1[31:0]} + {1'b0, addend};

    assign shamt = shf_one ? 5'd1 : op2[4:0];
    // extra low bit catches the last bit shifted out
    assign sar_ext = $signed({op1[31:0], 1'b0}) >>> shamt;
    assign sal_ext = {1'b0, op1[31:0]} << shamt;

    always_comb begin
        penc_idx = 5'd0;
        for (int i = 0; i < 32; i++) begin
            if (op1[i]) begin
                penc_idx = 5'(i);
            end
        end
    end
    assign penc_none = (op1[31:0] == 32'd0);

    // decimal adjust, both tests on the original byte
    assign daa_lo   = (op1[3:0] > 4'd9) || af_in;
    assign daa_hi   = (op1[7:0] > 8'h99) || cf_in;
    assign daa_byte = op1[7:0] + (daa_lo ? 8'h06 : 8'h00) + (daa_hi ? 8'h60 : 8'h00);

    assign eq = (op1[31:0] == op3[31:0]);

    // cleared only for a failed compare to memory
    assign op1_dest = (op == exe_pkg::ALU_CMPXCHG && cmpxchg_mem && !eq) ? 32'd0 : op1_orig;

    //////////////////////////////////////////////////
    // result and raw flag info
    //////////////////////////////////////////////////

    always_comb begin
        result     = 64'd0;
        cout       = 1'b0;
        aout       = 1'b0;
        ovf        = 1'b0;
        sh_out_bit = 1'b0;
        case (op)
            exe_pkg::ALU_AND: begin
                result = op1 & (and_mask ? exe_pkg::AND_LOW_MASK : op2);
            end
            exe_pkg::ALU_ADD: begin
                result = {{32{sum[31]}}, sum[31:0]};
                cout   = sum[32];
                aout   = op1[4] ^ addend[4] ^ sum[4];
                ovf    = (op1[31] == addend[31]) && (sum[31] != op1[31]);
            end
            exe_pkg::ALU_PENC:    result = {59'd0, penc_idx};
            exe_pkg::ALU_PASSB:   result = op2;
            exe_pkg::ALU_PASSA:   result = op1;
            exe_pkg::ALU_CLD:     result = 64'd0;
            exe_pkg::ALU_STD:     result = 64'd1;
            exe_pkg::ALU_CMPXCHG: result = eq ? op2 : op1;
            exe_pkg::ALU_DAA: begin
                result = {56'd0, daa_byte};
                aout   = daa_lo;
                cout   = daa_hi;
            end
            exe_pkg::ALU_NOT: result = ~op1;
            exe_pkg::ALU_OR:  result = op1 | op2;
            exe_pkg::ALU_SAR: begin
                result     = {32'd0, sar_ext[32:1]};
                // zero count keeps the old carry
                sh_out_bit = (shamt == 5'd0) ? cf_in : sar_ext[0];
            end
            exe_pkg::ALU_SAL: begin
                result     = {32'd0, sal_ext[31:0]};
                sh_out_bit = (shamt == 5'd0) ? cf_in : sal_ext[32];
            end
            default: result = 64'd0;
        endcase
    end

endmodule

// File: rtl/alu_simd_unit.sv
`timescale 1ns/1ps

module alu_simd_unit (
    input  exe_pkg::alu_op_e    op,
    input  logic [63:0]         op1,
    input  logic [63:0]         op2,
    output logic [63:0]         result,
    output logic                is_simd
);

    // signed saturation to a word, or to a byte in the low bits
    function automatic logic [15:0] sat_narrow(input logic signed [31:0] v,
                                               input logic to_byte);
        logic signed [31:0] hi;
        logic signed [31:0] lo;
        hi = to_byte ? 32'sd127 : 32'sd32767;
        lo = to_byte ? -32'sd128 : -32'sd32768;
        if (v > hi) begin
            return hi[15:0];
        end else if (v < lo) begin
            return lo[15:0];
        end
        return v[15:0];
    endfunction

    always_comb begin
        result  = 64'd0;
        is_simd = 1'b1;
        case (op)
            exe_pkg::ALU_PADDW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 16] = op1[16*i +: 16] + op2[16*i +: 16];
                end
            end
            exe_pkg::ALU_PADDD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 32] = op1[32*i +: 32] + op2[32*i +: 32];
                end
            end
            exe_pkg::ALU_PACKSSWB: begin
                // op1 words into the low four bytes
                for (int i = 0; i < 4; i++) begin
                    result[8*i +: 8]      = 8'(sat_narrow(32'($signed(op1[16*i +: 16])), 1'b1));
                    result[8*i + 32 +: 8] = 8'(sat_narrow(32'($signed(op2[16*i +: 16])), 1'b1));
                end
            end
            exe_pkg::ALU_PACKSSDW: begin
                for (int i = 0; i < 2; i++) begin
                    result[16*i +: 16]      = sat_narrow($signed(op1[32*i +: 32]), 1'b0);
                    result[16*i + 32 +: 16] = sat_narrow($signed(op2[32*i +: 32]), 1'b0);
                end
            end
            exe_pkg::ALU_PUNPCKHBW: begin
                for (int i = 0; i < 4; i++) begin
                    result[16*i +: 8]     = op1[32 + 8*i +: 8];
                    result[16*i + 8 +: 8] = op2[32 + 8*i +: 8];
                end
            end
            exe_pkg::ALU_PUNPCKHWD: begin
                for (int i = 0; i < 2; i++) begin
                    result[32*i +: 16]      = op1[32 + 16*i +: 16];
                    result[32*i + 16 +: 16] = op2[32 + 16*i +: 16];
                end
            end
            default: is_simd = 1'b0;
        endcase
    end

endmodule

// File: rtl/alu_flag_unit.sv
`timescale 1ns/1ps

module alu_flag_unit (
    input  exe_pkg::alu_op_e    op,
    input  logic [63:0]         result,
    input  logic                cout,
    input  logic                aout,
    input  logic                ovf,
    input  logic                sh_out_bit,
    input  logic                eq,
    input  logic                penc_none,
    input  exe_pkg::eflags_t    flags_in,
    output exe_pkg::eflags_t    flags_out
);

    logic pf_res;
    logic zf_res;
    logic sf_res;

    // even parity of the low byte
    assign pf_res = ~^result[7:0];
    assign zf_res = (result[31:0] == 32'd0);
    assign sf_res = result[31];

    always_comb begin
        flags_out = flags_in;
        case (op)
            exe_pkg::ALU_AND, exe_pkg::ALU_OR: begin
                flags_out.cf = 1'b0;
                flags_out.of = 1'b0;
                flags_out.zf = zf_res;
                flags_out.sf = sf_res;
                flags_out.pf = pf_res;
            end
            exe_pkg::ALU_ADD: begin
                flags_out.cf = cout;
                flags_out.of = ovf;
                flags_out.af = aout;
                flags_out.zf = zf_res;
                flags_out.sf = sf_res;
                flags_out.pf = pf_res;
            end
            exe_pkg::ALU_PENC:    flags_out.zf = penc_none;
            exe_pkg::ALU_CMPXCHG: flags_out.zf = eq;
            exe_pkg::ALU_DAA: begin
                // adjusted value lives in al only
                flags_out.cf = cout;
                flags_out.af = aout;
                flags_out.zf = (result[7:0] == 8'd0);
                flags_out.sf = result[7];
                flags_out.pf = pf_res;
            end
            exe_pkg::ALU_SAR, exe_pkg::ALU_SAL: begin
                flags_out.cf = sh_out_bit;
                flags_out.zf = zf_res;
                flags_out.sf = sf_res;
                flags_out.pf = pf_res;
            end
            exe_pkg::ALU_CLD: flags_out.df = 1'b0;
            exe_pkg::ALU_STD: flags_out.df = 1'b1;
            default: flags_out = flags_in;
        endcase
    end

endmodule

// File: rtl/exe_top.sv
`timescale 1ns/1ps

module exe_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [exe_pkg::OP_W-1:0]    in_op,
    input  logic [63:0]                 in_op1,
    input  logic [63:0]                 in_op2,
    input  logic [63:0]                 in_op3,
    input  logic [31:0]                 in_op1_orig,
    input  logic [2:0]                  in_adder_imm,
    input  logic                        in_and_mask,
    input  logic                        in_shf_one,
    input  logic                        in_cmpxchg_mem,
    input  logic [6:0]                  in_flags,
    input  logic [exe_pkg::TAG_W-1:0]   in_tag,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [63:0]                 out_result,
    output logic [31:0]                 out_op1_dest,
    output logic [6:0]                  out_flags,
    output logic [exe_pkg::TAG_W-1:0]   out_tag
);

    exe_stage_if #(.payload_t(exe_pkg::uop_t)) in_if ();
    exe_stage_if #(.payload_t(exe_pkg::uop_t)) op_if ();
    exe_stage_if #(.payload_t(exe_pkg::res_t)) res_if ();
    exe_stage_if #(.payload_t(exe_pkg::res_t)) out_if ();

    exe_pkg::uop_t      uop;
    logic [63:0]        int_result;
    logic [63:0]        simd_result;
    logic [63:0]        alu_result;
    logic [31:0]        op1_dest;
    logic               cout;
    logic               aout;
    logic               ovf;
    logic               sh_out_bit;
    logic               eq;
    logic               penc_none;
    logic               is_simd;
    exe_pkg::eflags_t   flags_out;

    //////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////

    assign in_if.valid   = in_valid;
    assign in_if.tag     = in_tag;
    assign in_if.payload = '{op: exe_pkg::alu_op_e'(in_op), op1: in_op1, op2: in_op2,
                             op3: in_op3, op1_orig: in_op1_orig, adder_imm: in_adder_imm,
                             and_mask: in_and_mask, shf_one: in_shf_one,
                             cmpxchg_mem: in_cmpxchg_mem,
                             flags: exe_pkg::eflags_t'(in_flags), tag: in_tag};
    assign in_ready      = in_if.ready;

    exe_pipe_reg #(.payload_t(exe_pkg::uop_t)) u_in_reg (
        .clk(clk), .rst_n(rst_n), .up(in_if.dst), .down(op_if.src)
    );

    //////////////////////////////////////////////////
    // alu, zero latency
    //////////////////////////////////////////////////

    assign uop = op_if.payload;

    alu_int_unit u_int (
        .op(uop.op), .op1(uop.op1), .op2(uop.op2), .op3(uop.op3),
        .op1_orig(uop.op1_orig), .adder_imm(uop.adder_imm), .and_mask(uop.and_mask),
        .shf_one(uop.shf_one), .cmpxchg_mem(uop.cmpxchg_mem),
        .cf_in(uop.flags.cf), .af_in(uop.flags.af),
        .result(int_result), .op1_dest(op1_dest), .cout(cout), .aout(aout), .ovf(ovf),
        .sh_out_bit(sh_out_bit), .eq(eq), .penc_none(penc_none)
    );

    alu_simd_unit u_simd (
        .op(uop.op), .op1(uop.op1), .op2(uop.op2),
        .result(simd_result), .is_simd(is_simd)
    );

    assign alu_result = is_simd ? simd_result : int_result;

    alu_flag_unit u_flag (
        .op(uop.op), .result(alu_result), .cout(cout), .aout(aout), .ovf(ovf),
        .sh_out_bit(sh_out_bit), .eq(eq), .penc_none(penc_none),
        .flags_in(uop.flags), .flags_out(flags_out)
    );

    // middle stage just forwards the handshake
    assign res_if.valid   = op_if.valid;
    assign res_if.tag     = op_if.tag;
    assign res_if.payload = '{result: alu_result, op1_dest: op1_dest,
                              flags: flags_out, tag: uop.tag};
    assign op_if.ready    = res_if.ready;

    a_op_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_if.valid |-> !$isunknown(uop.op)
    ) else $error("unknown alu opcode in execute stage");

    //////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////

    exe_pipe_reg #(.payload_t(exe_pkg::res_t)) u_out_reg (
        .clk(clk), .rst_n(rst_n), .up(res_if.dst), .down(out_if.src)
    );

    assign out_valid    = out_if.valid;
    assign out_if.ready = out_ready;
    assign out_result   = out_if.payload.result;
    assign out_op1_dest = out_if.payload.op1_dest;
    assign out_flags    = out_if.payload.flags;
    assign out_tag      = out_if.tag;

endmodule

// File: tests/tb_exe_top.sv
`timescale 1ns/1ps

module tb_exe_top;

    localparam int WORDS    = 13;
    localparam int MAX_VEC  = 48;
    localparam int MEM_SIZE = 1 + WORDS * MAX_VEC;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic           in_ready;
    logic [4:0]     in_op;
    logic [63:0]    in_op1;
    logic [63:0]    in_op2;
    logic [63:0]    in_op3;
    logic [31:0]    in_op1_orig;
    logic [2:0]     in_adder_imm;
    logic           in_and_mask;
    logic           in_shf_one;
    logic           in_cmpxchg_mem;
    logic [6:0]     in_flags;
    logic [3:0]     in_tag;
    logic           out_valid;
    logic           out_ready;
    logic [63:0]    out_result;
    logic [31:0]    out_op1_dest;
    logic [6:0]     out_flags;
    logic [3:0]     out_tag;

    // word 0 is the vector count, then WORDS words per vector
    logic [63:0]    vec_mem [0:MEM_SIZE-1];
    int             exp_q [$];
    int             num_vec;
    int             in_idx;
    int             out_count;
    int             error_count;
    int             cycle_count;
    int             cycle_limit;
    int             seed;
    logic           pending;

    exe_top u_exe_top (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_op(in_op),
        .in_op1(in_op1), .in_op2(in_op2), .in_op3(in_op3), .in_op1_orig(in_op1_orig),
        .in_adder_imm(in_adder_imm), .in_and_mask(in_and_mask), .in_shf_one(in_shf_one),
        .in_cmpxchg_mem(in_cmpxchg_mem), .in_flags(in_flags), .in_tag(in_tag),
        .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result),
        .out_op1_dest(out_op1_dest), .out_flags(out_flags), .out_tag(out_tag)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic drive_vector(input int idx);
        int b;
        b = 1 + idx * WORDS;
        in_op          = vec_mem[b][4:0];
        in_op1         = vec_mem[b+1];
        in_op2         = vec_mem[b+2];
        in_op3         = vec_mem[b+3];
        in_op1_orig    = vec_mem[b+4][31:0];
        in_adder_imm   = vec_mem[b+5][2:0];
        in_and_mask    = vec_mem[b+6][0];
        in_shf_one     = vec_mem[b+7][0];
        in_cmpxchg_mem = vec_mem[b+8][0];
        in_flags       = vec_mem[b+9][6:0];
        // tags count up with the vector index
        in_tag         = idx[3:0];
    endtask

    task automatic report_mismatch(input string field, input int idx,
                                   input logic [63:0] got, input logic [63:0] want);
        $display("[FAIL] %0t ns: %s of vector %0d is %h, expected %h",
                 $time, field, idx, got, want);
        error_count++;
    endtask

    task automatic check_output();
        int idx;
        int b;
        if (exp_q.size() == 0) begin
            $display("result with tag %0d came out with no op outstanding at %0t ns",
                     out_tag, $time);
            error_count++;
        end else begin
            idx = exp_q.pop_front();
            b   = 1 + idx * WORDS;
            assert (out_tag === idx[3:0])
                else report_mismatch("tag", idx, 64'(out_tag), 64'(idx[3:0]));
            assert (out_result === vec_mem[b+10])
                else report_mismatch("result", idx, out_result, vec_mem[b+10]);
            assert (out_op1_dest === vec_mem[b+11][31:0])
                else report_mismatch("op1_dest", idx, 64'(out_op1_dest),
                                     64'(vec_mem[b+11][31:0]));
            assert (out_flags === vec_mem[b+12][6:0])
                else report_mismatch("flags", idx, 64'(out_flags), 64'(vec_mem[b+12][6:0]));
        end
    endtask

    task automatic finish_run(input logic aborted);
        $display("errors: %0d  ops sent: %0d  results checked: %0d of %0d",
                 error_count, in_idx, out_count, num_vec);
        if (error_count == 0 && !aborted) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // hang guard
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the pipeline stopped delivering results",
                     cycle_count);
            finish_run(1'b1);
        end
    end

    //////////////////////////////////////////////////
    // stimulus and scoreboard
    //////////////////////////////////////////////////

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        in_op          = 5'd0;
        in_op1         = 64'd0;
        in_op2         = 64'd0;
        in_op3         = 64'd0;
        in_op1_orig    = 32'd0;
        in_adder_imm   = 3'd0;
        in_and_mask    = 1'b0;
        in_shf_one     = 1'b0;
        in_cmpxchg_mem = 1'b0;
        in_flags       = 7'd0;
        in_tag         = 4'd0;
        out_ready      = 1'b0;
        in_idx         = 0;
        out_count      = 0;
        error_count    = 0;
        cycle_count    = 0;
        pending        = 1'b0;
        seed           = 21050;

        $readmemh("tests/exe_testdata.txt", vec_mem);
        num_vec     = int'(vec_mem[0][15:0]);
        cycle_limit = 20 * num_vec + 100;

        if (num_vec == 0 || num_vec > MAX_VEC) begin
            $display("data file gave an unusable vector count of %0d", num_vec);
            finish_run(1'b1);
        end else begin
            repeat (8) @(posedge clk);
            #1;
            rst_n = 1'b1;
            assert (out_valid === 1'b0 && in_ready === 1'b1) else begin
                $display("[FAIL] %0t ns: after reset out_valid=%b in_ready=%b",
                         $time, out_valid, in_ready);
                error_count++;
            end

            while (out_count < num_vec) begin
                // handshake values are settled mid cycle
                @(negedge clk);
                if (in_valid && in_ready) begin
                    exp_q.push_back(in_idx);
                    in_idx++;
                    pending = 1'b0;
                end
                if (out_valid && out_ready) begin
                    check_output();
                    out_count++;
                end
                @(posedge clk);
                #1;
                out_ready = ($unsigned($random(seed)) % 10) >= 3;
                if (!pending) begin
                    if (in_idx < num_vec && ($random(seed) & 3) != 0) begin
                        drive_vector(in_idx);
                        in_valid = 1'b1;
                        pending  = 1'b1;
                    end else begin
                        in_valid = 1'b0;
                    end
                end
            end

            // nothing may follow the last result
            in_valid  = 1'b0;
            out_ready = 1'b1;
            repeat (4) begin
                @(negedge clk);
                if (out_valid) begin
                    $display("extra result with tag %0d after the last op at %0t ns",
                             out_tag, $time);
                    error_count++;
                end
            end
            assert (exp_q.size() == 0) else begin
                $display("%0d ops never came out of the pipeline", exp_q.size());
                error_count++;
            end
            finish_run(1'b0);
        end
    end

endmodule

// File: tests/exe_testdata.txt
// columns: op op1 op2 op3 op1_orig adder_imm and_mask shf_one cmpxchg_mem flags_in
// then expected result op1_dest flags_out; all hex, flags are {cf pf af zf sf of df}
// vector count
25
01 7fffffff 1 0 12345678 0 0 0 0 00 ffffffff80000000 12345678 36
01 ffffffff 1 0 12345678 0 0 0 0 00 0 12345678 78
01 10 0 0 12345678 1 0 0 0 01 12 12345678 21
01 c 0 0 12345678 2 0 0 0 00 10 12345678 10
01 5 0 0 12345678 3 0 0 0 40 5 12345678 20
01 7b 0 0 12345678 4 0 0 0 00 81 12345678 30
01 1 0 0 12345678 5 0 0 0 00 ffffffffffffffff 12345678 24
01 4 0 0 12345678 6 0 0 0 00 0 12345678 78
01 80000000 55 0 12345678 7 0 0 0 00 ffffffff80000000 12345678 24
00 ff00ff00f0f0f0f0 0f0f0f0fffff0000 0 12345678 0 0 0 0 42 0f000f00f0f00000 12345678 24
00 ffffffffffff1234 0 0 12345678 0 1 0 0 50 1234 12345678 10
0a 8000000000000000 0 0 12345678 0 0 0 0 02 8000000000000000 12345678 28
09 ffff 0 0 12345678 0 0 0 0 55 ffffffffffff0000 12345678 55
04 0123456789abcdef 0 0 12345678 0 0 0 0 0a 0123456789abcdef 12345678 0a
03 1 fedcba9876543210 0 12345678 0 0 0 0 00 fedcba9876543210 12345678 00
02 12345 0 0 12345678 0 0 0 0 08 10 12345678 00
02 ffffffff00000000 0 0 12345678 0 0 0 0 41 0 12345678 49
05 0 0 0 12345678 0 0 0 0 7f 0 12345678 7e
06 0 0 0 12345678 0 0 0 0 00 1 12345678 01
07 aaaa 123456789abcdef0 aaaa 13572468 0 0 0 1 00 123456789abcdef0 13572468 08
07 aaaa 123456789abcdef0 aaab 13572468 0 0 0 1 08 aaaa 0 00
07 5 9 6 13572468 0 0 0 0 48 5 13572468 40
07 100000007 77 7 13572468 0 0 0 0 00 77 13572468 08
08 f 0 0 12345678 0 0 0 0 00 15 12345678 10
08 a0 0 0 12345678 0 0 0 0 00 0 12345678 68
08 ffffff9a 0 0 12345678 0 0 0 0 00 0 12345678 78
08 45 0 0 12345678 0 0 0 0 50 ab 12345678 54
11 80000018 4 0 12345678 0 0 0 0 00 f8000001 12345678 44
12 c0000001 2 0 12345678 0 0 0 0 00 4 12345678 40
11 3 1f 0 12345678 0 0 1 0 01 1 12345678 41
12 40000000 0 0 12345678 0 0 1 0 40 80000000 12345678 24
0b 7fffffff00018000 00010001ffff8000 0 12345678 0 0 0 0 3c 8000000000000000 12345678 3c
0c 7fffffffffffffff 100000002 0 12345678 0 0 0 0 00 8000000000000001 12345678 00
0d 7fff80000050ff80 0080ff7f007f0000 0 12345678 0 0 0 0 7f 7f807f007f805080 12345678 7f
0e ffff7fff00010000 00001234ffffffff 0 12345678 0 0 0 0 02 1234ffff80007fff 12345678 02
0f 44332211aaaaaaaa 88776655bbbbbbbb 0 12345678 0 0 0 0 00 8844773366225511 12345678 00
10 ddddcccc00000000 22221111ffffffff 0 12345678 0 0 0 0 14 2222dddd1111cccc 12345678 14

// File: tb.f
rtl/exe_pkg.sv
rtl/exe_stage_if.sv
rtl/exe_pipe_reg.sv
rtl/alu_int_unit.sv
rtl/alu_simd_unit.sv
rtl/alu_flag_unit.sv
rtl/exe_top.sv
tests/tb_exe_top.sv

// File: run.sh
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_exe_top

out=$(./obj_dir/Vtb_exe_top)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
